/* include/csr_defines.svh */
//////////////////////////////////////////////////
// Width and constant values of the CSR unit
// Include in any file that sizes CSR data paths
//////////////////////////////////////////////////

`ifndef CSR_DEFINES_SVH
`define CSR_DEFINES_SVH

// Data width of every CSR and of the instruction operand
`define CSR_XLEN 32

// Hart number returned by reads of mhartid
`define CSR_HART_ID 32'h0000_0000

// RV32I with the I extension bit set, MXL field says 32 bit
`define CSR_MISA_VALUE 32'h4000_0100

// Trap vector base after reset, mode bits must stay zero
`define CSR_MTVEC_RESET 32'h0000_0100

`endif

/* source/csr_pkg.sv */
//////////////////////////////////////////////////
// Shared types of the machine-mode CSR unit
//////////////////////////////////////////////////

package csr_pkg;

  // Standard addresses of the implemented CSRs
  typedef enum logic [11:0] {
    CSR_MSTATUS  = 12'h300,
    CSR_MISA     = 12'h301,
    CSR_MTVEC    = 12'h305,
    CSR_MSCRATCH = 12'h340,
    CSR_MEPC     = 12'h341,
    CSR_MCAUSE   = 12'h342,
    CSR_DPC      = 12'h7B1,
    CSR_MHARTID  = 12'hF14
  } csr_num_e;

  // Operation carried by the CSR instruction
  // Set and clear use the operand as a bit mask on the old value
  typedef enum logic [1:0] {
    CSR_OP_READ  = 2'b00,
    CSR_OP_WRITE = 2'b01,
    CSR_OP_SET   = 2'b10,
    CSR_OP_CLEAR = 2'b11
  } csr_op_e;

  // Encoding of machine mode in the mpp field
  localparam logic [1:0] PRIV_LVL_M = 2'b11;

  // Machine status register
  // Only the machine-mode interrupt bits and mpp exist here
  typedef struct packed {
    logic [18:0] rsv_31_13;
    logic [1:0]  mpp;
    logic [2:0]  rsv_10_8;
    logic        mpie;
    logic [2:0]  rsv_6_4;
    logic        mie;
    logic [2:0]  rsv_2_0;
  } mstatus_t;

  // Machine cause register, interrupt flag on top of the cause code
  typedef struct packed {
    logic        irq;
    logic [30:0] code;
  } mcause_t;

endpackage

/* source/csr_decode.sv */
//////////////////////////////////////////////////
// Address and operation decode of a CSR instruction
// Feeds the register select and access checks
//////////////////////////////////////////////////

module csr_decode (
  input  logic              csr_valid_i,
  input  logic [11:0]       csr_addr_i,
  input  csr_pkg::csr_op_e  csr_op_i,
  output csr_pkg::csr_num_e sel_o,
  output logic              wr_o,
  output logic              illegal_o
);
  import csr_pkg::*;

  logic known;
  logic read_only;
  logic modify;

  //////////////////////////////////////////////////
  // Address match
  //////////////////////////////////////////////////

  // Only the eight implemented addresses are known
  // An unknown address still drives a harmless select value
  always_comb begin
    known = 1'b1;
    sel_o = CSR_MSTATUS;
    case (csr_addr_i)
      CSR_MSTATUS:  sel_o = CSR_MSTATUS;
      CSR_MISA:     sel_o = CSR_MISA;
      CSR_MTVEC:    sel_o = CSR_MTVEC;
      CSR_MSCRATCH: sel_o = CSR_MSCRATCH;
      CSR_MEPC:     sel_o = CSR_MEPC;
      CSR_MCAUSE:   sel_o = CSR_MCAUSE;
      CSR_DPC:      sel_o = CSR_DPC;
      CSR_MHARTID:  sel_o = CSR_MHARTID;
      default: begin
        known = 1'b0;
      end
    endcase
  end

  //////////////////////////////////////////////////
  // Access checks
  //////////////////////////////////////////////////

  // Top address bits both set mark a read-only CSR by convention
  // misa is writable in the standard but held constant in this unit
  assign read_only = (csr_addr_i[11:10] == 2'b11) || (csr_addr_i == CSR_MISA);

  // Every operation other than read may change the register
  assign modify = (csr_op_i != CSR_OP_READ);

  // Illegal for an unknown address or a modifying access to a read-only one
  assign illegal_o = csr_valid_i && (!known || (read_only && modify));

  // Write intent only for a legal access, traps and halt are handled downstream
  assign wr_o = csr_valid_i && known && !(read_only && modify) && modify;

endmodule

/* source/csr_regfile.sv */
//////////////////////////////////////////////////
// Writable machine-mode CSRs with trap, return
// and debug updates next to instruction writes
//////////////////////////////////////////////////

`include "csr_defines.svh"

module csr_regfile (
  input  logic                 clk,
  input  logic                 arst_n_i,
  input  logic                 wr_i,
  input  csr_pkg::csr_num_e    sel_i,
  input  csr_pkg::csr_op_e     csr_op_i,
  input  logic [`CSR_XLEN-1:0] csr_wdata_i,
  input  logic [`CSR_XLEN-1:0] old_value_i,
  input  logic                 halt_i,
  input  logic                 trap_i,
  input  logic [`CSR_XLEN-1:0] trap_pc_i,
  input  logic [`CSR_XLEN-1:0] trap_cause_i,
  input  logic                 mret_i,
  input  logic                 debug_i,
  input  logic [`CSR_XLEN-1:0] debug_pc_i,
  output csr_pkg::mstatus_t    mstatus_o,
  output logic [`CSR_XLEN-1:0] mtvec_o,
  output logic [`CSR_XLEN-1:0] mepc_o,
  output logic [`CSR_XLEN-1:0] mscratch_o,
  output logic [`CSR_XLEN-1:0] dpc_o,
  output csr_pkg::mcause_t     mcause_o,
  output logic                 killed_o
);
  import csr_pkg::*;

  logic                 csr_we;
  logic [`CSR_XLEN-1:0] new_value;
  mstatus_t             wr_status;
  logic                 mie_q;
  logic                 mpie_q;
  logic [`CSR_XLEN-1:0] mtvec_q;
  logic [`CSR_XLEN-1:0] mepc_q;
  logic [`CSR_XLEN-1:0] mscratch_q;
  logic [`CSR_XLEN-1:0] dpc_q;
  mcause_t              mcause_q;

  //////////////////////////////////////////////////
  // Instruction write path
  //////////////////////////////////////////////////

  // Any side-band pulse takes the cycle and the instruction is dropped
  assign killed_o = trap_i || debug_i || mret_i;

  // Halt lets the instruction finish but nothing is written
  assign csr_we = wr_i && !halt_i && !killed_o;

  // New value from the old one, before the per-register masks
  always_comb begin
    case (csr_op_i)
      CSR_OP_WRITE: new_value = csr_wdata_i;
      CSR_OP_SET:   new_value = old_value_i | csr_wdata_i;
      CSR_OP_CLEAR: new_value = old_value_i & ~csr_wdata_i;
      default:      new_value = old_value_i;
    endcase
  end

  assign wr_status = new_value;

  //////////////////////////////////////////////////
  // Register update
  //////////////////////////////////////////////////

  // Trap wins over debug, debug over mret, mret over the instruction
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mie_q      <= 1'b0;
      mpie_q     <= 1'b0;
      mtvec_q    <= `CSR_MTVEC_RESET;
      mepc_q     <= '0;
      mscratch_q <= '0;
      dpc_q      <= '0;
      mcause_q   <= '0;
    end else if (trap_i) begin
      mepc_q   <= {trap_pc_i[`CSR_XLEN-1:1], 1'b0};
      mcause_q <= trap_cause_i;
      mpie_q   <= mie_q;
      mie_q    <= 1'b0;
    end else if (debug_i) begin
      dpc_q <= {debug_pc_i[`CSR_XLEN-1:1], 1'b0};
    end else if (mret_i) begin
      mie_q  <= mpie_q;
      mpie_q <= 1'b1;
    end else if (csr_we) begin
      case (sel_i)
        CSR_MSTATUS: begin
          // Only the two interrupt enables are writable
          mie_q  <= wr_status.mie;
          mpie_q <= wr_status.mpie;
        end
        CSR_MTVEC:    mtvec_q    <= {new_value[`CSR_XLEN-1:2], 2'b00};
        CSR_MSCRATCH: mscratch_q <= new_value;
        CSR_MEPC:     mepc_q     <= {new_value[`CSR_XLEN-1:1], 1'b0};
        CSR_MCAUSE:   mcause_q   <= new_value;
        CSR_DPC:      dpc_q      <= {new_value[`CSR_XLEN-1:1], 1'b0};
        default: begin
        end
      endcase
    end
  end

  // Only machine mode exists, so mpp always reads as machine
  always_comb begin
    mstatus_o      = '0;
    mstatus_o.mie  = mie_q;
    mstatus_o.mpie = mpie_q;
    mstatus_o.mpp  = PRIV_LVL_M;
  end

  assign mtvec_o    = mtvec_q;
  assign mepc_o     = mepc_q;
  assign mscratch_o = mscratch_q;
  assign dpc_o      = dpc_q;
  assign mcause_o   = mcause_q;

endmodule

/* source/csr_result.sv */
//////////////////////////////////////////////////
// CSR read mux and the registered result
//////////////////////////////////////////////////

`include "csr_defines.svh"

module csr_result (
  input  logic                 clk,
  input  logic                 arst_n_i,
  input  logic                 csr_valid_i,
  input  csr_pkg::csr_num_e    sel_i,
  input  logic                 illegal_i,
  input  logic                 killed_i,
  input  csr_pkg::mstatus_t    mstatus_i,
  input  logic [`CSR_XLEN-1:0] mtvec_i,
  input  logic [`CSR_XLEN-1:0] mepc_i,
  input  logic [`CSR_XLEN-1:0] mscratch_i,
  input  logic [`CSR_XLEN-1:0] dpc_i,
  input  csr_pkg::mcause_t     mcause_i,
  output logic [`CSR_XLEN-1:0] old_value_o,
  output logic                 done_o,
  output logic [`CSR_XLEN-1:0] rdata_o,
  output logic                 illegal_o
);
  import csr_pkg::*;

  // Current value of the addressed CSR, also the base for set and clear
  always_comb begin
    case (sel_i)
      CSR_MSTATUS:  old_value_o = mstatus_i;
      CSR_MISA:     old_value_o = `CSR_MISA_VALUE;
      CSR_MTVEC:    old_value_o = mtvec_i;
      CSR_MSCRATCH: old_value_o = mscratch_i;
      CSR_MEPC:     old_value_o = mepc_i;
      CSR_MCAUSE:   old_value_o = mcause_i;
      CSR_DPC:      old_value_o = dpc_i;
      CSR_MHARTID:  old_value_o = `CSR_HART_ID;
      default:      old_value_o = '0;
    endcase
  end

  // A killed instruction leaves no trace, an illegal one returns zero
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      done_o    <= 1'b0;
      illegal_o <= 1'b0;
      rdata_o   <= '0;
    end else begin
      done_o    <= csr_valid_i && !killed_i;
      illegal_o <= illegal_i && !killed_i;
      rdata_o   <= illegal_i ? '0 : old_value_o;
    end
  end

endmodule

/* source/csr_unit.sv */
//////////////////////////////////////////////////
// Machine-mode CSR unit for a writeback stage
// Result arrives one cycle after csr_valid_i
//////////////////////////////////////////////////

`include "csr_defines.svh"

module csr_unit (
  input  logic                 clk,
  input  logic                 arst_n_i,
  input  logic                 csr_valid_i,
  input  logic [11:0]          csr_addr_i,
  input  csr_pkg::csr_op_e     csr_op_i,
  input  logic [`CSR_XLEN-1:0] csr_wdata_i,
  input  logic                 halt_i,
  input  logic                 trap_i,
  input  logic [`CSR_XLEN-1:0] trap_pc_i,
  input  logic [`CSR_XLEN-1:0] trap_cause_i,
  input  logic                 mret_i,
  input  logic                 debug_i,
  input  logic [`CSR_XLEN-1:0] debug_pc_i,
  output logic                 done_o,
  output logic [`CSR_XLEN-1:0] rdata_o,
  output logic                 illegal_o,
  output logic [`CSR_XLEN-1:0] mtvec_o,
  output logic [`CSR_XLEN-1:0] mepc_o,
  output logic                 mie_o
);
  import csr_pkg::*;

  csr_num_e             sel;
  logic                 wr;
  logic                 illegal;
  logic                 killed;
  logic [`CSR_XLEN-1:0] old_value;
  mstatus_t             mstatus;
  logic [`CSR_XLEN-1:0] mscratch;
  logic [`CSR_XLEN-1:0] dpc;
  mcause_t              mcause;

  csr_decode decode_i (
    .csr_valid_i (csr_valid_i),
    .csr_addr_i  (csr_addr_i),
    .csr_op_i    (csr_op_i),
    .sel_o       (sel),
    .wr_o        (wr),
    .illegal_o   (illegal)
  );

  csr_regfile regfile_i (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .wr_i         (wr),
    .sel_i        (sel),
    .csr_op_i     (csr_op_i),
    .csr_wdata_i  (csr_wdata_i),
    .old_value_i  (old_value),
    .halt_i       (halt_i),
    .trap_i       (trap_i),
    .trap_pc_i    (trap_pc_i),
    .trap_cause_i (trap_cause_i),
    .mret_i       (mret_i),
    .debug_i      (debug_i),
    .debug_pc_i   (debug_pc_i),
    .mstatus_o    (mstatus),
    .mtvec_o      (mtvec_o),
    .mepc_o       (mepc_o),
    .mscratch_o   (mscratch),
    .dpc_o        (dpc),
    .mcause_o     (mcause),
    .killed_o     (killed)
  );

  csr_result result_i (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .csr_valid_i (csr_valid_i),
    .sel_i       (sel),
    .illegal_i   (illegal),
    .killed_i    (killed),
    .mstatus_i   (mstatus),
    .mtvec_i     (mtvec_o),
    .mepc_i      (mepc_o),
    .mscratch_i  (mscratch),
    .dpc_i       (dpc),
    .mcause_i    (mcause),
    .old_value_o (old_value),
    .done_o      (done_o),
    .rdata_o     (rdata_o),
    .illegal_o   (illegal_o)
  );

  // Global interrupt enable for the core
  assign mie_o = mstatus.mie;

endmodule

/* bench/csr_unit_properties.sv */
//////////////////////////////////////////////////
// Concurrent checks on the CSR register file
// Attached to every csr_regfile by the bind below
//////////////////////////////////////////////////

`include "csr_defines.svh"

module csr_unit_properties (
  input logic                 clk,
  input logic                 arst_n_i,
  input logic                 wr_i,
  input logic                 halt_i,
  input logic                 trap_i,
  input logic                 mret_i,
  input logic                 debug_i,
  input logic [`CSR_XLEN-1:0] trap_pc_i,
  input csr_pkg::mstatus_t    mstatus_i,
  input logic [`CSR_XLEN-1:0] mtvec_i,
  input logic [`CSR_XLEN-1:0] mepc_i,
  input logic [`CSR_XLEN-1:0] mscratch_i,
  input logic [`CSR_XLEN-1:0] dpc_i,
  input csr_pkg::mcause_t     mcause_i,
  input logic                 killed_i
);

  // Saved pc values never have bit 0 set
  localparam logic [`CSR_XLEN-1:0] PC_MASK = {{(`CSR_XLEN-1){1'b1}}, 1'b0};

  // With halt high and no side-band pulse, nothing may change
  halt_blocks_writes: assert property (@(posedge clk) disable iff (!arst_n_i)
    halt_i && !killed_i |=> mstatus_i == $past(mstatus_i) && mtvec_i == $past(mtvec_i)
      && mepc_i == $past(mepc_i) && mscratch_i == $past(mscratch_i)
      && dpc_i == $past(dpc_i) && mcause_i == $past(mcause_i))
    else $error("A register changed while halt was high");

  // The trap pc lands in mepc on the next edge
  trap_loads_mepc: assert property (@(posedge clk) disable iff (!arst_n_i)
    trap_i |=> mepc_i == ($past(trap_pc_i) & PC_MASK))
    else $error("mepc does not hold the trap pc after a trap");

  mtvec_mode_zero: assert property (@(posedge clk) disable iff (!arst_n_i)
    mtvec_i[1:0] == 2'b00)
    else $error("mtvec mode bits are not zero");

  // A write that meets a trap, debug or mret pulse is dropped
  // None of the pulses touches mtvec or mscratch, so both must hold still
  pulse_kills_write: assert property (@(posedge clk) disable iff (!arst_n_i)
    wr_i && (trap_i || debug_i || mret_i) |=> $past(killed_i)
      && mtvec_i == $past(mtvec_i) && mscratch_i == $past(mscratch_i))
    else $error("A side-band pulse did not kill the coinciding write");

endmodule

bind csr_regfile csr_unit_properties props_i (
  .clk        (clk),
  .arst_n_i   (arst_n_i),
  .wr_i       (wr_i),
  .halt_i     (halt_i),
  .trap_i     (trap_i),
  .mret_i     (mret_i),
  .debug_i    (debug_i),
  .trap_pc_i  (trap_pc_i),
  .mstatus_i  (mstatus_o),
  .mtvec_i    (mtvec_o),
  .mepc_i     (mepc_o),
  .mscratch_i (mscratch_o),
  .dpc_i      (dpc_o),
  .mcause_i   (mcause_o),
  .killed_i   (killed_o)
);

/* bench/csr_unit_tb.sv */
//////////////////////////////////////////////////
// Random testbench of the CSR unit, a shadow model
// predicts every output and a checker compares them
//////////////////////////////////////////////////

`include "csr_defines.svh"

module csr_unit_tb;
  import csr_pkg::*;

  localparam int NUM_CYCLES     = 400;
  localparam int TIMEOUT_CYCLES = 500;

  // mscratch and mtvec come up twice as often, the last four are not implemented
  localparam logic [11:0] ADDRESSES [14] = '{
    CSR_MSCRATCH, CSR_MSCRATCH, CSR_MTVEC, CSR_MTVEC, CSR_MSTATUS, CSR_MISA, CSR_MEPC,
    CSR_MCAUSE, CSR_DPC, CSR_MHARTID, 12'h344, 12'hC00, 12'h7B0, 12'h000
  };

  logic                 clk;
  logic                 arst_n_i;
  logic                 csr_valid_i;
  logic [11:0]          csr_addr_i;
  csr_op_e              csr_op_i;
  logic [`CSR_XLEN-1:0] csr_wdata_i;
  logic                 halt_i;
  logic                 trap_i, mret_i, debug_i;
  logic [`CSR_XLEN-1:0] trap_pc_i, trap_cause_i, debug_pc_i;
  logic                 done_o, illegal_o, mie_o;
  logic [`CSR_XLEN-1:0] rdata_o, mtvec_o, mepc_o;

  // Shadow copy of the CSRs and the outputs expected after the last edge
  logic                 m_mie, m_mpie;
  logic [`CSR_XLEN-1:0] m_mtvec, m_mepc, m_mscratch, m_dpc, m_mcause;
  logic                 exp_done, exp_illegal;
  logic [`CSR_XLEN-1:0] exp_rdata;
  int                   cycle_count = 0;

  csr_unit dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  // Result of an operation on the old value, kept to the writable bits
  function automatic logic [31:0] masked_update(csr_op_e op, logic [31:0] old_value,
                                                logic [31:0] wdata, logic [31:0] mask);
    logic [31:0] raw;
    case (op)
      CSR_OP_WRITE: raw = wdata;
      CSR_OP_SET:   raw = old_value | wdata;
      CSR_OP_CLEAR: raw = old_value & ~wdata;
      default:      raw = old_value;
    endcase
    return raw & mask;
  endfunction

  function automatic logic is_implemented(logic [11:0] addr);
    return addr inside {CSR_MSTATUS, CSR_MISA, CSR_MTVEC, CSR_MSCRATCH,
                        CSR_MEPC, CSR_MCAUSE, CSR_DPC, CSR_MHARTID};
  endfunction

  // mpp always reads as machine mode
  function automatic logic [31:0] shadow_read(logic [11:0] addr);
    case (addr)
      CSR_MSTATUS:  return {19'b0, 2'b11, 3'b0, m_mpie, 3'b0, m_mie, 3'b0};
      CSR_MISA:     return `CSR_MISA_VALUE;
      CSR_MTVEC:    return m_mtvec;
      CSR_MSCRATCH: return m_mscratch;
      CSR_MEPC:     return m_mepc;
      CSR_MCAUSE:   return m_mcause;
      CSR_DPC:      return m_dpc;
      CSR_MHARTID:  return `CSR_HART_ID;
      default:      return '0;
    endcase
  endfunction

  // One step per rising edge, trap before debug before mret before the write
  always @(posedge clk) begin
    logic [31:0] old_value;
    logic [31:0] new_value;
    logic        bad;
    if (!arst_n_i) begin
      {m_mie, m_mpie, m_mepc, m_mscratch, m_dpc, m_mcause} = '0;
      m_mtvec     = `CSR_MTVEC_RESET;
      exp_done    = 1'b0;
      exp_illegal = 1'b0;
      exp_rdata   = '0;
    end else begin
      old_value   = shadow_read(csr_addr_i);
      bad         = !is_implemented(csr_addr_i) || (csr_op_i != CSR_OP_READ &&
                    (csr_addr_i[11:10] == 2'b11 || csr_addr_i == CSR_MISA));
      exp_done    = csr_valid_i && !(trap_i || debug_i || mret_i);
      exp_illegal = exp_done && bad;
      exp_rdata   = bad ? '0 : old_value;
      if (trap_i) begin
        m_mepc   = trap_pc_i & ~32'h1;
        m_mcause = trap_cause_i;
        m_mpie   = m_mie;
        m_mie    = 1'b0;
      end else if (debug_i) begin
        m_dpc = debug_pc_i & ~32'h1;
      end else if (mret_i) begin
        m_mie  = m_mpie;
        m_mpie = 1'b1;
      end else if (exp_done && !bad && !halt_i && csr_op_i != CSR_OP_READ) begin
        case (csr_addr_i)
          CSR_MSTATUS: begin
            new_value = masked_update(csr_op_i, old_value, csr_wdata_i, 32'h88);
            m_mie     = new_value[3];
            m_mpie    = new_value[7];
          end
          CSR_MTVEC:    m_mtvec    = masked_update(csr_op_i, old_value, csr_wdata_i, ~32'h3);
          CSR_MSCRATCH: m_mscratch = masked_update(csr_op_i, old_value, csr_wdata_i, '1);
          CSR_MEPC:     m_mepc     = masked_update(csr_op_i, old_value, csr_wdata_i, ~32'h1);
          CSR_MCAUSE:   m_mcause   = masked_update(csr_op_i, old_value, csr_wdata_i, '1);
          CSR_DPC:      m_dpc      = masked_update(csr_op_i, old_value, csr_wdata_i, ~32'h1);
          default: begin
          end
        endcase
      end
    end
  end

  //////////////////////////////////////////////////
  // Checker and run limit
  //////////////////////////////////////////////////

  task automatic report_mismatch(string name, logic [31:0] expected, logic [31:0] actual);
    $display("FAIL time=%0t signal=%s expected=%h actual=%h", $time, name, expected, actual);
    $display("Regression failed");
    $fatal(1, "Stopped at the first mismatch");
  endtask

  // Outputs are compared on the falling edge, half a cycle after they settle
  always @(negedge clk) begin
    if (arst_n_i) begin
      assert (done_o == exp_done)
        else report_mismatch("done_o", 32'(exp_done), 32'(done_o));
      assert (illegal_o == exp_illegal)
        else report_mismatch("illegal_o", 32'(exp_illegal), 32'(illegal_o));
      assert (mtvec_o == m_mtvec)
        else report_mismatch("mtvec_o", m_mtvec, mtvec_o);
      assert (mepc_o == m_mepc)
        else report_mismatch("mepc_o", m_mepc, mepc_o);
      assert (mie_o == m_mie)
        else report_mismatch("mie_o", 32'(m_mie), 32'(mie_o));
      if (exp_done) begin
        assert (rdata_o == exp_rdata)
          else report_mismatch("rdata_o", exp_rdata, rdata_o);
      end
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, the test did not reach its end", cycle_count);
      $display("Regression failed");
      $fatal(1, "Run stopped by the cycle limit");
    end
  end

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  task automatic set_idle();
    {csr_valid_i, halt_i, trap_i, mret_i, debug_i} = '0;
    csr_addr_i   = '0;
    csr_op_i     = CSR_OP_READ;
    csr_wdata_i  = '0;
    trap_pc_i    = '0;
    trap_cause_i = '0;
    debug_pc_i   = '0;
  endtask

  // Half the operands only touch the mstatus interrupt bits
  task automatic drive_random_cycle();
    logic [1:0] op_bits;
    op_bits      = 2'($urandom % 4);
    csr_valid_i  = ($urandom % 100) < 65;
    csr_addr_i   = ADDRESSES[4'($urandom % 14)];
    csr_op_i     = csr_op_e'(op_bits);
    csr_wdata_i  = ($urandom % 2 == 0) ? $urandom : ($urandom & 32'h0000_0088);
    halt_i       = ($urandom % 100) < 15;
    trap_i       = ($urandom % 100) < 7;
    mret_i       = ($urandom % 100) < 7;
    debug_i      = ($urandom % 100) < 5;
    trap_pc_i    = $urandom;
    trap_cause_i = $urandom;
    debug_pc_i   = $urandom;
  endtask

  initial begin
    void'($urandom(32'hcadeb5c9));
    arst_n_i = 1'b0;
    set_idle();
    repeat (4) @(posedge clk);
    #1 arst_n_i = 1'b1;
    repeat (NUM_CYCLES) begin
      @(posedge clk);
      #1 drive_random_cycle();
    end
    @(posedge clk);
    #1 set_idle();
    // Let the checker finish its last falling-edge compare first
    repeat (2) @(negedge clk);
    #1;
    $display("Regression passed");
    $finish;
  end

endmodule

/* csr_unit.f */
+incdir+include
source/csr_pkg.sv
source/csr_decode.sv
source/csr_regfile.sv
source/csr_result.sv
source/csr_unit.sv
bench/csr_unit_properties.sv
bench/csr_unit_tb.sv

/* run.sh */
#!/bin/sh
# Builds the CSR unit testbench with Verilator and runs it
# The run counts as passed only when the log holds the pass message

rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module csr_unit_tb \
  -f csr_unit.f -o csr_unit_sim || { echo "Build failed"; exit 1; }

./obj_dir/csr_unit_sim > sim.log 2>&1
cat sim.log
grep -q "Regression passed" sim.log && echo "Simulation ok" || { echo "Simulation not ok"; exit 1; }
